/* pid_controller.f */
+incdir+logic
logic/pid_pkg.sv
logic/oversample_filter.sv
logic/pid_core.sv
logic/router.sv
logic/output_preprocessor.sv
logic/dac_instr_queue.sv
logic/dac_controller.sv
logic/pid_controller.sv
sim/pid_controller_tb.sv

/* sim/pid_controller_tb.sv */
`include "pid_ctrl_config.svh"

module pid_controller_tb import pid_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SPACING    = 700;                          // cycles per sample window
	localparam int N_SAMPLES  = 74;                           // 6 + 8 + 12 + 8 + 40
	localparam int MAX_CYCLES = N_SAMPLES * SPACING + 2000;
	localparam int PID_MAX    = (1 << (`W_PID - 1)) - 1;
	localparam int PID_MIN    = -(1 << (`W_PID - 1));

	logic      clk50;
	logic      rst;
	adc_bus_t  adc;
	ctrl_cfg_t cfg;
	logic      update;
	logic      dac_nsync;
	logic      dac_sclk;
	logic      dac_din;

	// model state mirroring the shadow registers and per channel history
	ctrl_cfg_t shadow;
	int        osf_cnt [`N_ADC];
	longint    osf_sum [`N_ADC];
	int        integ [`N_ADC];
	int        prev_err [`N_ADC];
	int        code [`N_DAC];
	dac_cmd_t  exp_q [$];          // frames still to come in order
	int        frames_expected;
	int        frames_seen;

	logic [`W_FRAME-1:0] frame_bits;
	int                  nbits;
	bit                  in_frame;
	int                  cycles;
	logic [31:0]         rng_state = 32'h28f8_71a5;

	pid_controller pid_controller_i (
		.clk50     (clk50),
		.rst       (rst),
		.adc       (adc),
		.cfg       (cfg),
		.update    (update),
		.dac_nsync (dac_nsync),
		.dac_sclk  (dac_sclk),
		.dac_din   (dac_din)
	);

	always #20 clk50 = ~clk50;   // 40 ns period

	always @(posedge clk50) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			abort_run("timeout, the run did not finish within the cycle limit");
	end

	////////////////////////////////////////
	// failure reporting and compares
	////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s (time %0t)", reason, $time);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_cmd(input dac_cmd_t got, input dac_cmd_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got chan %0d data %0d, expected chan %0d data %0d",
				$time, what, got.chan, got.data, exp.chan, exp.data);
			$display("TESTBENCH FAILED");
			$fatal(1, "frame mismatch");
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("CHECK FAILED at %0t: %s got %0d, expected %0d", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	////////////////////////////////////////
	// frame decoder
	////////////////////////////////////////

	always @(negedge dac_nsync) begin
		in_frame = 1'b1;
		nbits    = 0;
	end

	// dac takes din on the falling sclk
	always @(negedge dac_sclk) begin
		if (dac_nsync === 1'b0) begin
			frame_bits = {frame_bits[`W_FRAME-2:0], dac_din};
			nbits++;
		end
	end

	always @(posedge dac_nsync) begin : frame_end
		dac_cmd_t got;
		dac_cmd_t exp;
		if (in_frame) begin
			in_frame = 1'b0;
			got.chan = frame_bits[22:20];
			got.data = frame_bits[19:4];
			if (nbits != `W_FRAME) begin
				abort_run($sformatf("frame had %0d bits instead of %0d", nbits, `W_FRAME));
			end else if (frame_bits[31:24] != {4'b0, 4'(`DAC_CMD)} || frame_bits[23]) begin
				abort_run($sformatf("frame header is wrong: %h", frame_bits));
			end else if (frame_bits[3:0] != 4'b0) begin
				abort_run($sformatf("frame tail bits are not zero: %h", frame_bits));
			end else if (exp_q.size() == 0) begin
				abort_run("a frame came out that the model did not expect");
			end else begin
				frames_seen++;
				exp = exp_q.pop_front();
				check_cmd(got, exp, "dac frame");
			end
		end
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// shadow load on update restarts the filter blocks
	function automatic void load_shadow(input ctrl_cfg_t c);
		shadow = c;
		for (int ch = 0; ch < `N_ADC; ch++) begin
			osf_cnt[ch] = 0;
			osf_sum[ch] = 0;
			if (!c.pid.lock_mask[ch]) begin
				integ[ch]    = 0;   // unlocked core keeps no history
				prev_err[ch] = 0;
			end
		end
	endfunction

	// one adc sample through filter, pid, router and preprocessor
	// pushes the frames it causes and returns how many
	function automatic int predict_frames(input int ch, input int value);
		int     avg;
		int     sp;
		int     err;
		int     integ_next;
		int     deriv;
		int     p;
		int     i;
		int     d;
		longint acc;
		longint scaled;
		int     pid_out;
		bit     lock;
		int     sum;
		int     n;
		n = 0;
		if (osf_cnt[ch] != (1 << shadow.pid.osm) - 1) begin
			osf_cnt[ch]++;                    // block not complete yet
			osf_sum[ch] += value;
			return 0;
		end
		avg         = int'((osf_sum[ch] + value) >>> shadow.pid.osm);
		osf_cnt[ch] = 0;
		osf_sum[ch] = 0;
		lock        = shadow.pid.lock_mask[ch];
		sp          = $signed(shadow.pid.setpoint);
		p           = $signed(shadow.pid.p_coef);
		i           = $signed(shadow.pid.i_coef);
		d           = $signed(shadow.pid.d_coef);
		if (lock) begin
			err        = sp - avg;
			integ_next = integ[ch] + err;   // 32 bit wrap
			deriv      = err - prev_err[ch];
			acc        = longint'(p) * err + longint'(i) * integ_next + longint'(d) * deriv;
			scaled     = acc >>> `PID_SHIFT;
			if (scaled > PID_MAX)
				pid_out = PID_MAX;
			else if (scaled < PID_MIN)
				pid_out = PID_MIN;
			else
				pid_out = int'(scaled);
			integ[ch]    = integ_next;
			prev_err[ch] = err;
		end else begin
			pid_out      = 0;
			integ[ch]    = 0;
			prev_err[ch] = 0;
		end
		for (int k = 0; k < `N_DAC; k++) begin
			if (shadow.routes[k].active && shadow.routes[k].src == ch) begin
				if (lock) begin
					sum = code[k] + pid_out * int'($signed(shadow.opp.mult));
					if (sum > int'(shadow.opp.out_max))
						code[k] = shadow.opp.out_max;
					else if (sum < int'(shadow.opp.out_min))
						code[k] = shadow.opp.out_min;
					else
						code[k] = sum;
				end else begin
					code[k] = shadow.opp.out_init;
				end
				exp_q.push_back('{chan: `W_DAC_CHS'(k), data: `W_DAC_DATA'(code[k])});
				n++;
			end
		end
		return n;
	endfunction

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	function automatic ctrl_cfg_t base_cfg();
		ctrl_cfg_t c;
		c                = '0;
		c.pid.setpoint   = 16'sd1000;
		c.pid.p_coef     = 16'sd256;      // unity gain after the shift
		c.pid.lock_mask  = '1;
		c.opp.out_max    = 16'hffff;
		c.opp.mult       = 8'sd1;
		return c;
	endfunction

	function automatic ctrl_cfg_t draw_cfg();
		ctrl_cfg_t   c;
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] r;
		c              = '0;
		r              = xorshift32();
		c.pid.setpoint = r[15:0];
		c.pid.p_coef   = 16'($signed(r[27:16]));   // 12 bit signed gains
		r              = xorshift32();
		c.pid.i_coef   = 16'($signed(r[11:0]));
		c.pid.d_coef   = 16'($signed(r[23:12]));
		c.pid.osm      = {2'b0, r[24]};
		c.pid.lock_mask = r[30:25];
		r              = xorshift32();
		for (int k = 0; k < `N_DAC; k++)
			c.routes[k] = '{active: r[k], src: `W_SRC'(xorshift32() % `N_ADC)};
		a              = xorshift32();
		b              = xorshift32();
		c.opp.out_min  = (a < b) ? a : b;
		c.opp.out_max  = (a < b) ? b : a;
		r              = xorshift32();
		c.opp.out_init = r[15:0];
		c.opp.mult     = r[23:16];
		return c;
	endfunction

	task automatic apply_cfg(input ctrl_cfg_t c);
		@(posedge clk50);
		#2;
		cfg    = c;
		update = 1'b1;
		@(posedge clk50);
		#2;
		update = 1'b0;
		load_shadow(c);
	endtask

	// new settings on the port without the update strobe
	task automatic preset_cfg(input ctrl_cfg_t c);
		@(posedge clk50);
		#2;
		cfg = c;
	endtask

	task automatic send_sample(input int ch, input int value);
		@(posedge clk50);
		#2;
		adc.valid         = '0;
		adc.valid[ch]     = 1'b1;
		adc.sample[ch]    = adc_word_t'(value);
		frames_expected  += predict_frames(ch, value);
		@(posedge clk50);
		#2;
		adc.valid = '0;
		repeat (SPACING - 1) @(posedge clk50);   // all frames of this sample are out
		check_count(frames_seen, frames_expected, "frame count after sample");
	endtask

	task automatic quiet_after_reset();
		repeat (100) begin
			@(negedge clk50);
			if (dac_nsync !== 1'b1 || dac_sclk !== 1'b0)
				abort_run("nsync or sclk left the idle level with no samples applied");
		end
	endtask

	task automatic proportional_only();
		ctrl_cfg_t c;
		int        vals [6] = '{0, -5000, 1500, 40000, -20000, 777};
		c           = base_cfg();
		c.routes[5] = '{active: 1'b1, src: 3'd2};
		apply_cfg(c);
		foreach (vals[n])
			send_sample(2, vals[n]);
	endtask

	task automatic oversample_blocks();
		ctrl_cfg_t c;
		int        vals [8] = '{100, 300, -200, 600, 9000, 8000, 7000, 6001};
		c           = base_cfg();
		c.pid.osm   = 3'd2;                      // frame every fourth sample
		c.routes[5] = '{active: 1'b1, src: 3'd2};
		apply_cfg(c);
		foreach (vals[n])
			send_sample(2, vals[n]);
	endtask

	task automatic pid_terms_clamp();
		ctrl_cfg_t c;
		int        vals [12] = '{120000, 120000, 120000, -120000, -120000, -120000,
			-120000, 5000, -3000, 60000, -90000, 0};
		c              = base_cfg();
		c.pid.setpoint = 16'sd0;
		c.pid.p_coef   = 16'sd100;
		c.pid.i_coef   = 16'sd20;
		c.pid.d_coef   = -16'sd50;
		c.opp.mult     = -8'sd3;
		c.opp.out_min  = 16'd2000;
		c.opp.out_max  = 16'd40000;
		c.routes[0]    = '{active: 1'b1, src: 3'd4};
		apply_cfg(c);
		foreach (vals[n])
			send_sample(4, vals[n]);
	endtask

	task automatic routing_and_lock();
		ctrl_cfg_t c;
		ctrl_cfg_t c2;
		c               = base_cfg();
		c.pid.setpoint  = 16'sd0;
		c.pid.lock_mask = 6'b001010;             // ch1 and ch3 locked
		c.opp.out_init  = 16'd12345;
		c.opp.mult      = 8'sd2;
		c.routes[1]     = '{active: 1'b1, src: 3'd1};
		c.routes[3]     = '{active: 1'b1, src: 3'd1};
		c.routes[6]     = '{active: 1'b1, src: 3'd1};
		c.routes[4]     = '{active: 1'b1, src: 3'd0};   // unlocked source
		c.routes[7]     = '{active: 1'b0, src: 3'd1};
		apply_cfg(c);
		send_sample(1, -300);
		send_sample(1, 200);
		send_sample(0, 5000);
		send_sample(4, 1000);                    // routed nowhere
		c2               = base_cfg();
		c2.pid.setpoint  = 16'sd0;
		c2.pid.lock_mask = 6'b000011;
		c2.opp.out_init  = 16'd777;
		c2.routes[2]     = '{active: 1'b1, src: 3'd1};
		c2.routes[5]     = '{active: 1'b1, src: 3'd0};
		preset_cfg(c2);
		send_sample(1, 100);                     // old map still in force
		send_sample(0, 50);
		apply_cfg(c2);
		send_sample(1, -100);
		send_sample(0, 400);
	endtask

	task automatic random_samples();
		int          ch;
		adc_word_t   w;
		logic [31:0] r;
		for (int round = 0; round < 4; round++) begin
			apply_cfg(draw_cfg());
			for (int s = 0; s < 10; s++) begin
				ch = xorshift32() % `N_ADC;
				r  = xorshift32();
				w  = r[`W_ADC-1:0];
				send_sample(ch, int'(w));
			end
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		clk50           = 1'b0;
		rst             = 1'b1;
		update          = 1'b0;
		adc             = '0;
		cfg             = '0;
		shadow          = '0;
		frames_expected = 0;
		frames_seen     = 0;
		cycles          = 0;
		repeat (5) @(posedge clk50);
		#2;
		rst = 1'b0;
		quiet_after_reset();
		proportional_only();
		oversample_blocks();
		pid_terms_clamp();
		routing_and_lock();
		random_samples();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* logic/pid_controller.sv */
`include "pid_ctrl_config.svh"

module pid_controller import pid_pkg::*; (
	input  logic      clk50,
	input  logic      rst,
	input  adc_bus_t  adc,       // parallel samples with per channel strobes
	input  ctrl_cfg_t cfg,
	input  logic      update,    // shadow load strobe for every stage
	output logic      dac_nsync,
	output logic      dac_sclk,
	output logic      dac_din
);

	logic [`N_ADC-1:0]                  osf_valid;
	adc_word_t [`N_ADC-1:0]             osf_sample;
	pid_sample_t [`N_ADC-1:0]           pid_bus;   // router inputs
	pid_sample_t [`N_DAC-1:0]           rtr_bus;   // router outputs
	logic [`N_DAC-1:0]                  opp_valid;
	logic [`N_DAC-1:0][`W_DAC_DATA-1:0] opp_code;
	dac_cmd_t                           diq_cmd;
	logic                               diq_cmd_valid;
	logic                               dac_done;

	////////////////////////////////////////
	// per adc channel filter and pid
	////////////////////////////////////////

	for (genvar i = 0; i < `N_ADC; i++) begin : g_adc_chan
		oversample_filter osf_i (
			.clk50      (clk50),
			.rst        (rst),
			.update     (update),
			.osm        (cfg.pid.osm),
			.valid      (adc.valid[i]),
			.sample     (adc.sample[i]),
			.out_valid  (osf_valid[i]),
			.out_sample (osf_sample[i])
		);

		pid_core pid_i (
			.clk50  (clk50),
			.rst    (rst),
			.update (update),
			.cfg    (cfg.pid),
			.lock   (cfg.pid.lock_mask[i]),
			.valid  (osf_valid[i]),
			.sample (osf_sample[i]),
			.result (pid_bus[i])
		);
	end

	router rtr_i (
		.clk50   (clk50),
		.rst     (rst),
		.update  (update),
		.routes  (cfg.routes),
		.in_bus  (pid_bus),
		.out_bus (rtr_bus)
	);

	////////////////////////////////////////
	// per dac channel preprocessing
	////////////////////////////////////////

	for (genvar j = 0; j < `N_DAC; j++) begin : g_dac_chan
		output_preprocessor opp_i (
			.clk50     (clk50),
			.rst       (rst),
			.update    (update),
			.cfg       (cfg.opp),
			.in_sample (rtr_bus[j]),
			.valid     (opp_valid[j]),
			.code      (opp_code[j])
		);
	end

	dac_instr_queue diq_i (
		.clk50     (clk50),
		.rst       (rst),
		.valid     (opp_valid),
		.codes     (opp_code),
		.done      (dac_done),
		.cmd       (diq_cmd),
		.cmd_valid (diq_cmd_valid)
	);

	dac_controller dac_i (
		.clk50     (clk50),
		.rst       (rst),
		.cmd       (diq_cmd),
		.cmd_valid (diq_cmd_valid),
		.nsync     (dac_nsync),
		.sclk      (dac_sclk),
		.din       (dac_din),
		.done      (dac_done)
	);

endmodule

/* logic/dac_controller.sv */
`include "pid_ctrl_config.svh"

module dac_controller import pid_pkg::*; (
	input  logic     clk50,
	input  logic     rst,
	input  dac_cmd_t cmd,
	input  logic     cmd_valid,
	output logic     nsync,
	output logic     sclk,    // clk50 / 2 while nsync is low
	output logic     din,
	output logic     done     // one cycle after the frame gap
);

	localparam int N_HALF = 2 * `W_FRAME;      // sclk half periods per frame
	localparam int W_CNT  = $clog2(N_HALF);
	localparam int N_GAP  = 2;                 // nsync high cycles before done

	typedef enum logic [1:0] {IDLE, SHIFT, GAP} state_t;

	state_t              state;
	logic [W_CNT-1:0]    cnt;
	logic [`W_FRAME-1:0] frame;     // bits still to go, msb next
	logic [`W_FRAME-1:0] frame_w;

	// 0000 | cmd | address | data | 0000
	assign frame_w = {4'b0, 4'(`DAC_CMD), 4'(cmd.chan), cmd.data, 4'b0};

	////////////////////////////////////////
	// frame sequencer
	////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
			nsync <= 1'b1;
			sclk  <= 1'b0;
			din   <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (cmd_valid) begin
						nsync <= 1'b0;
						sclk  <= 1'b1;                  // first bit goes out with sclk high
						din   <= frame_w[`W_FRAME-1];
						frame <= frame_w << 1;
						cnt   <= '0;
						state <= SHIFT;
					end
				end
				SHIFT: begin
					if (cnt == W_CNT'(N_HALF - 1)) begin
						nsync <= 1'b1;   // frame complete
						sclk  <= 1'b0;
						din   <= 1'b0;
						cnt   <= '0;
						state <= GAP;
					end else begin
						cnt  <= cnt + 1'b1;
						sclk <= ~sclk;
						if (!sclk) begin                  // rising sclk, next bit
							din   <= frame[`W_FRAME-1];
							frame <= frame << 1;
						end
					end
				end
				GAP: begin
					cnt <= cnt + 1'b1;
					if (cnt == W_CNT'(N_GAP - 1)) begin
						done  <= 1'b1;
						cnt   <= '0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* logic/dac_instr_queue.sv */
`include "pid_ctrl_config.svh"

module dac_instr_queue import pid_pkg::*; (
	input  logic                              clk50,
	input  logic                              rst,
	input  logic [`N_DAC-1:0]                 valid,   // new code per channel
	input  logic [`N_DAC-1:0][`W_DAC_DATA-1:0] codes,
	input  logic                              done,    // controller finished a frame
	output dac_cmd_t                          cmd,
	output logic                              cmd_valid
);

	logic [`N_DAC-1:0]                  pending;   // code waiting to be sent
	logic [`N_DAC-1:0][`W_DAC_DATA-1:0] store;     // latest code per channel
	logic                               busy;      // command in flight
	logic                               issue;
	logic [`W_DAC_CHS-1:0]              sel;
	logic [`N_DAC-1:0]                  grant;

	////////////////////////////////////////
	// lowest pending channel wins
	////////////////////////////////////////

	always_comb begin
		sel = '0;
		for (int k = `N_DAC - 1; k >= 0; k--) begin
			if (pending[k])
				sel = `W_DAC_CHS'(k);
		end
	end

	assign issue = !busy && (|pending);
	assign grant = issue ? (`N_DAC'(1) << sel) : '0;

	always_ff @(posedge clk50) begin
		if (rst) begin
			pending   <= '0;
			busy      <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			pending   <= (pending & ~grant) | valid;  // a fresh code re-arms the bit
			cmd_valid <= issue;                       // single cycle strobe
			if (issue)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	// newer code replaces an unsent one
	always_ff @(posedge clk50) begin
		for (int k = 0; k < `N_DAC; k++) begin
			if (valid[k])
				store[k] <= codes[k];
		end
	end

	always_ff @(posedge clk50) begin
		if (issue)
			cmd <= '{chan: sel, data: store[sel]};
	end

endmodule

/* logic/output_preprocessor.sv */
`include "pid_ctrl_config.svh"

module output_preprocessor import pid_pkg::*; (
	input  logic                   clk50,
	input  logic                   rst,
	input  logic                   update,
	input  opp_cfg_t               cfg,
	input  pid_sample_t            in_sample,
	output logic                   valid,
	output logic [`W_DAC_DATA-1:0] code
);

	localparam int W_MULT = 8;
	localparam int W_ACC  = `W_PID + W_MULT + 2;   // code plus scaled step

	opp_cfg_t                 cfg_q;
	logic signed [W_ACC-1:0]  step;
	logic signed [W_ACC-1:0]  sum;
	logic signed [W_ACC-1:0]  lo;
	logic signed [W_ACC-1:0]  hi;
	logic [`W_DAC_DATA-1:0]   code_next;

	assign step = in_sample.data * cfg_q.mult;      // signed gain
	assign sum  = $signed({1'b0, code}) + step;     // integrate onto the code
	assign lo   = $signed({1'b0, cfg_q.out_min});
	assign hi   = $signed({1'b0, cfg_q.out_max});

	// clamp to [min, max]
	always_comb begin
		if (sum > hi)
			code_next = cfg_q.out_max;
		else if (sum < lo)
			code_next = cfg_q.out_min;
		else
			code_next = sum[`W_DAC_DATA-1:0];
	end

	always_ff @(posedge clk50) begin
		if (rst) begin
			cfg_q <= '0;
			valid <= 1'b0;
			code  <= '0;
		end else begin
			if (update)
				cfg_q <= cfg;
			valid <= in_sample.valid;
			if (in_sample.valid)
				code <= in_sample.lock ? code_next : cfg_q.out_init; // unlocked goes to init
		end
	end

endmodule

/* logic/router.sv */
`include "pid_ctrl_config.svh"

module router import pid_pkg::*; (
	input  logic                      clk50,
	input  logic                      rst,
	input  logic                      update,
	input  route_t [`N_DAC-1:0]       routes,
	input  pid_sample_t [`N_ADC-1:0]  in_bus,
	output pid_sample_t [`N_DAC-1:0]  out_bus
);

	route_t [`N_DAC-1:0] routes_q;   // shadowed map, all inactive after reset

	always_ff @(posedge clk50) begin
		if (rst) begin
			routes_q <= '0;
			out_bus  <= '0;
		end else begin
			if (update)
				routes_q <= routes;
			for (int k = 0; k < `N_DAC; k++) begin
				// a source index past the last pid channel counts as inactive
				if (routes_q[k].active && (routes_q[k].src < `N_ADC))
					out_bus[k] <= in_bus[routes_q[k].src];
				else
					out_bus[k].valid <= 1'b0;
			end
		end
	end

endmodule

/* logic/pid_core.sv */
`include "pid_ctrl_config.svh"

module pid_core import pid_pkg::*; (
	input  logic        clk50,
	input  logic        rst,
	input  logic        update,
	input  pid_cfg_t    cfg,
	input  logic        lock,     // this channel's bit of the lock mask
	input  logic        valid,
	input  adc_word_t   sample,
	output pid_sample_t result
);

	localparam int W_COEF = 16;
	localparam int W_ERR  = `W_ADC + 1;          // setpoint minus sample
	localparam int W_INT  = 32;                  // integral register
	localparam int W_ACC  = W_COEF + W_INT + 2;  // three products summed
	localparam logic signed [W_ACC-1:0] OUT_MAX = 2 ** (`W_PID - 1) - 1;
	localparam logic signed [W_ACC-1:0] OUT_MIN = -(2 ** (`W_PID - 1));

	logic signed [W_COEF-1:0] setpoint_q;
	logic signed [W_COEF-1:0] p_q;
	logic signed [W_COEF-1:0] i_q;
	logic signed [W_COEF-1:0] d_q;
	logic                     lock_q;
	logic signed [W_ERR-1:0]  err;
	logic signed [W_ERR-1:0]  prev_err;
	logic signed [W_ERR:0]    deriv;
	logic signed [W_INT-1:0]  integ;
	logic signed [W_INT-1:0]  integ_next;
	logic signed [W_ACC-1:0]  acc;
	logic signed [W_ACC-1:0]  scaled;
	logic signed [`W_PID-1:0] sat;
	logic                     res_lock;
	logic                     res_valid;
	logic signed [`W_PID-1:0] res_data;

	////////////////////////////////////////
	// correction term
	////////////////////////////////////////

	assign err        = setpoint_q - sample;
	assign integ_next = integ + err;    // wraps at 32 bits
	assign deriv      = err - prev_err;
	assign acc        = p_q * err + i_q * integ_next + d_q * deriv;
	assign scaled     = acc >>> `PID_SHIFT;

	// clip to the signed result range
	always_comb begin
		if (scaled > OUT_MAX)
			sat = OUT_MAX[`W_PID-1:0];
		else if (scaled < OUT_MIN)
			sat = OUT_MIN[`W_PID-1:0];
		else
			sat = scaled[`W_PID-1:0];
	end

	always_ff @(posedge clk50) begin
		if (rst) begin
			setpoint_q <= '0;
			p_q        <= '0;
			i_q        <= '0;
			d_q        <= '0;
			lock_q     <= 1'b0;
			integ      <= '0;
			prev_err   <= '0;
			res_lock   <= 1'b0;
			res_valid  <= 1'b0;
		end else begin
			if (update) begin         // shadow copy
				setpoint_q <= cfg.setpoint;
				p_q        <= cfg.p_coef;
				i_q        <= cfg.i_coef;
				d_q        <= cfg.d_coef;
				lock_q     <= lock;
			end
			res_valid <= valid;   // one cycle behind the filter
			if (valid)
				res_lock <= lock_q;
			if (!lock_q) begin
				integ    <= '0;     // unlocked core holds no history
				prev_err <= '0;
			end else if (valid) begin
				integ    <= integ_next;
				prev_err <= err;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (valid)
			res_data <= lock_q ? sat : '0;
	end

	assign result = '{lock: res_lock, valid: res_valid, data: res_data};

endmodule

/* logic/oversample_filter.sv */
`include "pid_ctrl_config.svh"

module oversample_filter import pid_pkg::*; (
	input  logic              clk50,
	input  logic              rst,
	input  logic              update,      // load osm shadow, restart block
	input  logic [`W_OSM-1:0] osm,         // block length is 2^osm
	input  logic              valid,
	input  adc_word_t         sample,
	output logic              out_valid,
	output adc_word_t         out_sample
);

	localparam int MAX_OSM = (1 << `W_OSM) - 1;  // largest shift
	localparam int W_SUM   = `W_ADC + MAX_OSM;   // room for 2^MAX_OSM samples
	localparam int W_CNT   = MAX_OSM + 1;

	logic [`W_OSM-1:0]       osm_q;       // shadowed mode
	logic [W_CNT-1:0]        count;       // samples taken in this block
	logic [W_CNT-1:0]        last_count;
	logic signed [W_SUM-1:0] sum;
	logic signed [W_SUM-1:0] sum_next;
	logic signed [W_SUM-1:0] avg;
	logic                    block_end;

	assign last_count = (W_CNT'(1) << osm_q) - W_CNT'(1);
	assign sum_next   = sum + sample;           // sign extended to W_SUM
	assign avg        = sum_next >>> osm_q;     // power of two average
	assign block_end  = valid && !update && (count == last_count);

	////////////////////////////////////////
	// accumulator and block counter
	////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (rst) begin
			osm_q     <= '0;
			count     <= '0;
			sum       <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (update) begin
				osm_q <= osm;
				count <= '0;   // new block starts with the new mode
				sum   <= '0;
			end else if (valid) begin
				if (block_end) begin
					count     <= '0;
					sum       <= '0;
					out_valid <= 1'b1;
				end else begin
					count <= count + 1'b1;
					sum   <= sum_next;
				end
			end
		end
	end

	// averaged sample, held until the next block
	always_ff @(posedge clk50) begin
		if (block_end)
			out_sample <= avg[`W_ADC-1:0];
	end

endmodule

/* logic/pid_pkg.sv */
`include "pid_ctrl_config.svh"

package pid_pkg;

	typedef logic signed [`W_ADC-1:0] adc_word_t; // one adc sample

	// raw parallel samples, one strobe per channel
	typedef struct packed {
		logic [`N_ADC-1:0]        valid;
		adc_word_t [`N_ADC-1:0]   sample;
	} adc_bus_t;

	// pid result word as carried through the router
	typedef struct packed {
		logic                     lock;  // lock enable of the source channel
		logic                     valid;
		logic signed [`W_PID-1:0] data;
	} pid_sample_t;

	// pid settings, shared by all six cores
	typedef struct packed {
		logic signed [15:0]       setpoint;
		logic signed [15:0]       p_coef;
		logic signed [15:0]       i_coef;
		logic signed [15:0]       d_coef;
		logic [`W_OSM-1:0]        osm;        // log2 of oversample ratio
		logic [`N_ADC-1:0]        lock_mask;  // one lock bit per channel
	} pid_cfg_t;

	// one router output
	typedef struct packed {
		logic                     active;
		logic [`W_SRC-1:0]        src;   // pid channel feeding this output
	} route_t;

	// output preprocessor settings
	typedef struct packed {
		logic [`W_DAC_DATA-1:0]   out_min;
		logic [`W_DAC_DATA-1:0]   out_max;
		logic [`W_DAC_DATA-1:0]   out_init;  // code while unlocked
		logic signed [7:0]        mult;      // gain on the routed correction
	} opp_cfg_t;

	typedef struct packed {
		pid_cfg_t                 pid;
		route_t [`N_DAC-1:0]      routes;
		opp_cfg_t                 opp;
	} ctrl_cfg_t;

	// one dac write
	typedef struct packed {
		logic [`W_DAC_CHS-1:0]    chan;
		logic [`W_DAC_DATA-1:0]   data;
	} dac_cmd_t;

endpackage

/* logic/pid_ctrl_config.svh */
`ifndef PID_CTRL_CONFIG_SVH
`define PID_CTRL_CONFIG_SVH

////////////////////////////////////////
// channel counts
////////////////////////////////////////

`define N_ADC       6   // adc input channels
`define N_DAC       8   // dac output channels

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define W_ADC       18  // adc sample width
`define W_PID       18  // pid result width
`define W_DAC_DATA  16  // dac code width
`define W_DAC_CHS   3   // dac channel index width
`define W_SRC       3   // router source index width
`define W_OSM       3   // oversample mode width

// pid sum is scaled down by this many bits before saturation
`define PID_SHIFT   8

// dac8568 serial frame
`define W_FRAME     32  // bits per frame
`define DAC_CMD     3   // write input register n and update n

`endif
